// ==== br_unit/br_eval.sv ====
// ##########################################################
// Branch evaluation
// Decodes class, checks condition on reg A, forms the
// recovery target and compares against the prediction
// ##########################################################
`timescale 1ns/1ns
`include "br_cfg.svh"

module br_eval
(
	input  br_pkg::br_req_t   req_i,
	output br_pkg::br_class_e cls_o,
	output logic              taken_o,
	output logic [`BR_XLEN-1:0] target_o,     // Recovery target
	output logic              mispredict_o
);

	import br_pkg::*;

	logic [5:0]          opcode;
	br_func_e            func;
	logic                cond_raw;  // Check before negate
	logic                cond;
	logic                opa_zero;
	logic                opa_neg;
	logic [`BR_XLEN-1:0] disp;      // Byte displacement
	logic [`BR_XLEN-1:0] taken_tgt;

	assign opcode = req_i.inst[31:26];
	assign func   = br_func_e'(req_i.inst[27:26]);

	assign opa_zero = (req_i.opa == '0);
	assign opa_neg  = req_i.opa[`BR_XLEN-1];

	// 21-bit word displacement, sign extended, times four
	assign disp = {{(`BR_XLEN-23){req_i.inst[20]}}, req_i.inst[20:0], 2'b00};

	// Class decode
	always_comb
	begin
		if (opcode[5:3] == OP_JMP_GRP[5:3])
			cls_o = CLS_JUMP;                          // 0x18..0x1F
		else if ((opcode == OP_BR) || (opcode == OP_BSR))
			cls_o = CLS_UNCOND;
		else if (opcode[5:4] == 2'b11)
			cls_o = CLS_COND;                          // Rest of 0x30..0x3F
		else
			cls_o = CLS_NONE;
	end

	// Condition on reg A
	always_comb
	begin
		case (func)
			FN_LBC:  cond_raw = ~req_i.opa[0];
			FN_EQ:   cond_raw = opa_zero;
			FN_LT:   cond_raw = opa_neg;
			FN_LE:   cond_raw = opa_neg | opa_zero;
			default: cond_raw = 1'b0;
		endcase
	end

	assign cond = cond_raw ^ req_i.inst[28]; // Bit 28 flips the sense

	// Direction by class
	always_comb
	begin
		case (cls_o)
			CLS_JUMP:   taken_o = 1'b1;
			CLS_UNCOND: taken_o = 1'b1;
			CLS_COND:   taken_o = cond;
			default:    taken_o = 1'b0;
		endcase
	end

	// Jumps go to reg A, word aligned; branches are PC relative
	assign taken_tgt = (cls_o == CLS_JUMP) ? {req_i.opa[`BR_XLEN-1:2], 2'b00}
		: req_i.npc + disp;

	assign target_o = taken_o ? taken_tgt : req_i.npc;

	// Wrong direction, or right direction but wrong place
	assign mispredict_o = (req_i.pred_taken != taken_o)
		| (taken_o & req_i.pred_taken & (req_i.pred_target != target_o));

endmodule

// ==== br_unit/fu_br.sv ====
// ##########################################################
// Branch functional unit
// One result register behind br_eval, stalls on res_s
// back-pressure and holds its output until drained
// ##########################################################
`timescale 1ns/1ns
`include "br_cfg.svh"

module fu_br
(
	input logic          clk,
	input logic          rst,
	br_stream_if.consumer iss_s, // br_req_t
	br_stream_if.producer res_s  // br_res_t
);

	import br_pkg::*;

	br_class_e           cls;
	logic                taken;
	logic [`BR_XLEN-1:0] target;
	logic                mispredict;

	br_res_t res_q;      // Output payload
	logic    res_vld_q;  // Output register occupied
	logic    accept;
	logic    drain;

	br_eval u_br_eval
	(
		.req_i        (iss_s.payload),
		.cls_o        (cls),
		.taken_o      (taken),
		.target_o     (target),
		.mispredict_o (mispredict)
	);

	// Free when empty or emptying this edge
	assign iss_s.ready = ~res_vld_q | res_s.ready;

	assign accept = iss_s.valid & iss_s.ready;
	assign drain  = res_vld_q & res_s.ready;

	// Valid bit
	always_ff @(posedge clk)
	begin
		if (rst)
			res_vld_q <= 1'b0;
		else if (accept)
			res_vld_q <= 1'b1;   // New result replaces any drained one
		else if (drain)
			res_vld_q <= 1'b0;
	end

	// Payload, only moves on accept so it holds during a stall
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			res_q.rob_idx    <= iss_s.payload.rob_idx;
			res_q.taken      <= taken;
			res_q.target     <= target;
			res_q.mispredict <= mispredict;
			res_q.is_cond    <= (cls == CLS_COND);
			res_q.npc        <= iss_s.payload.npc;
		end
	end

	assign res_s.valid   = res_vld_q;
	assign res_s.payload = res_q;

endmodule

// ==== common/br_cfg.svh ====
// ##########################################################
// Branch resolution configuration
// Widths and queue depth shared by package and RTL
// ##########################################################
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// Data path and PC width
`define BR_XLEN 64

// Reorder-buffer index width, 32 entries
`define BR_ROB_IDX_W 5

// Entries in each stream FIFO
`define BR_FIFO_DEPTH 4

`endif

// ==== common/br_pkg.sv ====
// ##########################################################
// Branch resolution types
// Class and condition encodings, opcodes, stream payloads
// ##########################################################
`include "br_cfg.svh"

package br_pkg;

	// Instruction class after decode
	typedef enum logic [1:0]
	{
		CLS_NONE   = 2'd0, // Not a branch
		CLS_JUMP   = 2'd1, // JMP/JSR/RET group
		CLS_UNCOND = 2'd2, // BR, BSR
		CLS_COND   = 2'd3  // Compare against reg A
	} br_class_e;

	// Condition check, from inst[27:26]
	typedef enum logic [1:0]
	{
		FN_LBC = 2'd0, // Low bit clear
		FN_EQ  = 2'd1, // Equal to zero
		FN_LT  = 2'd2, // Negative
		FN_LE  = 2'd3  // Negative or zero
	} br_func_e;

	// Major opcodes, inst[31:26]
	localparam logic [5:0] OP_BR      = 6'h30;
	localparam logic [5:0] OP_BSR     = 6'h34;
	localparam logic [5:0] OP_JMP_GRP = 6'h1a; // Upper three bits select the jump group

	// Issued branch operation, 230 bits
	typedef struct packed
	{
		logic [`BR_XLEN-1:0]      npc;         // PC of next sequential inst
		logic [`BR_XLEN-1:0]      opa;         // Register A value
		logic [31:0]              inst;
		logic [`BR_ROB_IDX_W-1:0] rob_idx;
		logic                     pred_taken;  // Front end direction guess
		logic [`BR_XLEN-1:0]      pred_target; // Front end target guess
	} br_req_t;

	// Resolution, 136 bits
	typedef struct packed
	{
		logic [`BR_ROB_IDX_W-1:0] rob_idx;
		logic                     taken;
		logic [`BR_XLEN-1:0]      target;     // Recovery target, npc if not taken
		logic                     mispredict;
		logic                     is_cond;    // Predictor only trains on these
		logic [`BR_XLEN-1:0]      npc;
	} br_res_t;

endpackage

// ==== common/br_stream_if.sv ====
// ##########################################################
// Valid/ready stream
// One payload per edge where valid and ready are both high
// ##########################################################
`timescale 1ns/1ns

interface br_stream_if #(
	parameter type payload_t = logic
) ();

	logic     valid;   // Producer has a word
	logic     ready;   // Consumer takes it this edge
	payload_t payload; // Held stable until transfer

	// Source side
	modport producer
	(
		output valid,
		output payload,
		input  ready
	);

	// Sink side
	modport consumer
	(
		input  valid,
		input  payload,
		output ready
	);

endinterface

// ==== design/br_exec_top.sv ====
// ##########################################################
// Branch execution top
// Request FIFO, branch unit and result FIFO in series,
// plain ports packed into and out of stream payloads
// ##########################################################
`timescale 1ns/1ns
`include "br_cfg.svh"

module br_exec_top
(
	input  logic                     clk,
	input  logic                     rst,
	// Issue side
	input  logic                     req_valid_i,
	output logic                     req_ready_o,
	input  logic [`BR_XLEN-1:0]      req_npc_i,
	input  logic [`BR_XLEN-1:0]      req_opa_i,
	input  logic [31:0]              req_inst_i,
	input  logic [`BR_ROB_IDX_W-1:0] req_rob_idx_i,
	input  logic                     req_pred_taken_i,
	input  logic [`BR_XLEN-1:0]      req_pred_target_i,
	// Resolution side, to ROB and predictor
	output logic                     res_valid_o,
	input  logic                     res_ready_i,
	output logic [`BR_ROB_IDX_W-1:0] res_rob_idx_o,
	output logic                     res_taken_o,
	output logic [`BR_XLEN-1:0]      res_target_o,
	output logic                     res_mispredict_o,
	output logic                     res_cond_o,
	output logic [`BR_XLEN-1:0]      res_npc_o
);

	import br_pkg::*;

	br_stream_if #(.payload_t(br_req_t)) req_q_s (); // Ports into request FIFO
	br_stream_if #(.payload_t(br_req_t)) iss_s ();   // Request FIFO to unit
	br_stream_if #(.payload_t(br_res_t)) res_s ();   // Unit to result FIFO
	br_stream_if #(.payload_t(br_res_t)) res_q_s (); // Result FIFO to ports

	// Pack request
	assign req_q_s.valid   = req_valid_i;
	assign req_q_s.payload = '{
		npc:         req_npc_i,
		opa:         req_opa_i,
		inst:        req_inst_i,
		rob_idx:     req_rob_idx_i,
		pred_taken:  req_pred_taken_i,
		pred_target: req_pred_target_i
	};
	assign req_ready_o = req_q_s.ready;

	br_fifo #(.payload_t(br_req_t)) u_req_q
	(
		.clk   (clk),
		.rst   (rst),
		.in_s  (req_q_s.consumer),
		.out_s (iss_s.producer)
	);

	fu_br u_fu_br
	(
		.clk   (clk),
		.rst   (rst),
		.iss_s (iss_s.consumer),
		.res_s (res_s.producer)
	);

	br_fifo #(.payload_t(br_res_t)) u_res_q
	(
		.clk   (clk),
		.rst   (rst),
		.in_s  (res_s.consumer),
		.out_s (res_q_s.producer)
	);

	// Unpack result
	assign res_q_s.ready    = res_ready_i;
	assign res_valid_o      = res_q_s.valid;
	assign res_rob_idx_o    = res_q_s.payload.rob_idx;
	assign res_taken_o      = res_q_s.payload.taken;
	assign res_target_o     = res_q_s.payload.target;
	assign res_mispredict_o = res_q_s.payload.mispredict;
	assign res_cond_o       = res_q_s.payload.is_cond;
	assign res_npc_o        = res_q_s.payload.npc;

endmodule

// ==== design/br_fifo.sv ====
// ##########################################################
// Stream FIFO
// First-word-fall-through ring buffer between two streams,
// head entry drives the output directly
// ##########################################################
`timescale 1ns/1ns
`include "br_cfg.svh"

module br_fifo #(
	parameter type payload_t = logic
)
(
	input logic          clk,
	input logic          rst,
	br_stream_if.consumer in_s,
	br_stream_if.producer out_s
);

	localparam int unsigned DEPTH = `BR_FIFO_DEPTH;
	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH]; // Storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;       // Occupied entries
	logic             push;
	logic             pop;

	// Wrap at DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
		return nxt;
	endfunction

	assign in_s.ready    = (count != CNT_W'(DEPTH)); // Low only when full
	assign out_s.valid   = (count != '0);
	assign out_s.payload = mem[rd_ptr];              // Fall through

	assign push = in_s.valid & in_s.ready;
	assign pop  = out_s.valid & out_s.ready;

	// Pointers and count
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Idle or both, level unchanged
			endcase
		end
	end

	// Write port
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_s.payload;
	end

endmodule

// ==== list.f ====
+incdir+common
common/br_pkg.sv
common/br_stream_if.sv
design/br_fifo.sv
br_unit/br_eval.sv
br_unit/fu_br.sv
design/br_exec_top.sv
verif/tb_br_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build the branch execution testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing -j 0 --timescale 1ns/1ns \
	--top-module tb_br_exec -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_br_exec" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== verif/tb_br_exec.sv ====
// ##########################################################
// Branch execution testbench
// Table of branch ops with worked-out results, pushed
// through the DUT under random and held back-pressure
// ##########################################################
`timescale 1ns/1ns
`include "br_cfg.svh"

module tb_br_exec;

	localparam int TIMEOUT      = 2000; // Cycles per wait
	localparam int MAX_INFLIGHT = 9;    // 4 queued, 1 in unit, 4 results
	localparam int MODE_RAND    = 0;    // res_ready_i modes
	localparam int MODE_LOW     = 1;
	localparam int MODE_HIGH    = 2;

	// PCs and operands used by the table
	localparam logic [`BR_XLEN-1:0] NPC    = 64'h0000_0000_0040_1000;
	localparam logic [`BR_XLEN-1:0] NPC_HI = 64'hffff_ffff_fff0_0008;
	localparam logic [`BR_XLEN-1:0] T_FWD  = 64'h0000_0000_0040_1010; // NPC + 16
	localparam logic [`BR_XLEN-1:0] T_BWD  = 64'h0000_0000_0040_0ff0; // NPC - 16
	localparam logic [`BR_XLEN-1:0] T_LOW  = 64'h0000_0000_0000_1000; // NPC - 4 MiB
	localparam logic [`BR_XLEN-1:0] OPA_Z  = 64'h0;
	localparam logic [`BR_XLEN-1:0] OPA_N  = 64'hffff_ffff_ffff_fff0; // Negative, even
	localparam logic [`BR_XLEN-1:0] OPA_P  = 64'h0000_0000_0000_0007; // Positive, odd
	localparam logic [`BR_XLEN-1:0] JA     = 64'h0000_1234_5678_9abf;
	localparam logic [`BR_XLEN-1:0] JA_T   = 64'h0000_1234_5678_9abc; // Low bits dropped
	localparam logic [`BR_XLEN-1:0] JB     = 64'h8000_0000_0000_0003;
	localparam logic [`BR_XLEN-1:0] JB_T   = 64'h8000_0000_0000_0000;
	localparam logic [20:0]         D_FWD  = 21'h000004; // +4 words
	localparam logic [20:0]         D_BWD  = 21'h1ffffc; // -4 words
	localparam logic [20:0]         D_MIN  = 21'h100000; // Most negative

	// One table row, rob_idx filled in at issue
	typedef struct
	{
		logic [31:0]              inst;
		logic [`BR_XLEN-1:0]      opa;
		logic [`BR_XLEN-1:0]      npc;
		logic                     pred_taken;
		logic [`BR_XLEN-1:0]      pred_target;
		logic [`BR_ROB_IDX_W-1:0] rob_idx;
		logic                     exp_taken;
		logic [`BR_XLEN-1:0]      exp_target; // Recovery target
		logic                     exp_mis;
		logic                     exp_cond;
	} op_t;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     req_valid_i;
	logic                     req_ready_o;
	logic [`BR_XLEN-1:0]      req_npc_i;
	logic [`BR_XLEN-1:0]      req_opa_i;
	logic [31:0]              req_inst_i;
	logic [`BR_ROB_IDX_W-1:0] req_rob_idx_i;
	logic                     req_pred_taken_i;
	logic [`BR_XLEN-1:0]      req_pred_target_i;
	logic                     res_valid_o;
	logic                     res_ready_i;
	logic [`BR_ROB_IDX_W-1:0] res_rob_idx_o;
	logic                     res_taken_o;
	logic [`BR_XLEN-1:0]      res_target_o;
	logic                     res_mispredict_o;
	logic                     res_cond_o;
	logic [`BR_XLEN-1:0]      res_npc_o;

	op_t ops[$];       // Stimulus table
	op_t exp_q[$];     // Accepted, not yet resolved
	int  seq = 0;      // Ops accepted so far
	int  ready_mode = MODE_LOW;
	int  stretch = 0;  // Cycles left in current res_ready_i level
	int  gap;
	int  fill_cnt;

	always #20 clk = ~clk;

	br_exec_top i_br_exec_top
	(
		.clk               (clk),
		.rst               (rst),
		.req_valid_i       (req_valid_i),
		.req_ready_o       (req_ready_o),
		.req_npc_i         (req_npc_i),
		.req_opa_i         (req_opa_i),
		.req_inst_i        (req_inst_i),
		.req_rob_idx_i     (req_rob_idx_i),
		.req_pred_taken_i  (req_pred_taken_i),
		.req_pred_target_i (req_pred_target_i),
		.res_valid_o       (res_valid_o),
		.res_ready_i       (res_ready_i),
		.res_rob_idx_o     (res_rob_idx_o),
		.res_taken_o       (res_taken_o),
		.res_target_o      (res_target_o),
		.res_mispredict_o  (res_mispredict_o),
		.res_cond_o        (res_cond_o),
		.res_npc_o         (res_npc_o)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [63:0] want,
		input logic [63:0] got);
		if (got !== want)
			abort_run($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, want, got));
	endtask

	// Opcode, ra = r3, 21-bit displacement
	function automatic logic [31:0] enc(input logic [5:0] opc, input logic [20:0] disp);
		return {opc, 5'd3, disp};
	endfunction

	task automatic add_op(input logic [31:0] inst, input logic [63:0] opa,
		input logic [63:0] npc, input logic pt, input logic [63:0] ptgt,
		input logic et, input logic [63:0] etgt, input logic em, input logic ec);
		op_t op;
		op = '{inst, opa, npc, pt, ptgt, '0, et, etgt, em, ec};
		ops.push_back(op);
	endtask

	task automatic build_table();
		// LBC, EQ, LT, LE against zero, negative, positive odd; predicted not taken
		add_op(enc(6'h38, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h38, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b1, T_BWD, 1'b1, 1'b1);
		add_op(enc(6'h38, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h39, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h39, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h39, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3a, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3a, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b1, T_BWD, 1'b1, 1'b1);
		add_op(enc(6'h3a, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3b, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3b, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b1, T_BWD, 1'b1, 1'b1);
		add_op(enc(6'h3b, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		// Negated forms LBS, NE, GE, GT
		add_op(enc(6'h3c, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3c, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3c, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3d, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3d, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b1, T_BWD, 1'b1, 1'b1);
		add_op(enc(6'h3d, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3e, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3e, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3e, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3f, D_FWD), OPA_Z, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3f, D_BWD), OPA_N, NPC, 1'b0, '0, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3f, D_FWD), OPA_P, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b1);
		// BR, BSR always taken, not conditional
		add_op(enc(6'h30, D_MIN), OPA_Z, NPC, 1'b1, T_LOW, 1'b1, T_LOW, 1'b0, 1'b0);
		add_op(enc(6'h34, D_BWD), OPA_P, NPC, 1'b1, T_BWD, 1'b1, T_BWD, 1'b0, 1'b0);
		add_op(enc(6'h30, D_FWD), OPA_N, NPC, 1'b0, '0, 1'b1, T_FWD, 1'b1, 1'b0);
		// Jumps to reg A, last one predicted with the unaligned address
		add_op(enc(6'h1a, D_FWD), JA, NPC, 1'b1, JA_T, 1'b1, JA_T, 1'b0, 1'b0);
		add_op(enc(6'h1b, D_BWD), JB, NPC, 1'b0, '0, 1'b1, JB_T, 1'b1, 1'b0);
		add_op(enc(6'h18, D_FWD), JA, NPC, 1'b1, JA, 1'b1, JA_T, 1'b1, 1'b0);
		// Not branches, fall through to npc
		add_op(enc(6'h10, D_FWD), OPA_Z, 64'h2004, 1'b0, '0, 1'b0, 64'h2004, 1'b0, 1'b0);
		add_op(enc(6'h29, D_BWD), OPA_N, NPC_HI, 1'b1, T_FWD, 1'b0, NPC_HI, 1'b1, 1'b0);
		add_op(enc(6'h08, D_FWD), OPA_P, 64'h0123_4564, 1'b0, '0, 1'b0, 64'h0123_4564,
			1'b0, 1'b0);
		// Prediction hits and misses on direction and target
		add_op(enc(6'h39, D_FWD), OPA_Z, NPC, 1'b1, T_FWD, 1'b1, T_FWD, 1'b0, 1'b1);
		add_op(enc(6'h39, D_FWD), OPA_Z, NPC, 1'b1, T_BWD, 1'b1, T_FWD, 1'b1, 1'b1);
		add_op(enc(6'h3d, D_FWD), OPA_Z, NPC, 1'b1, T_FWD, 1'b0, NPC, 1'b1, 1'b1);
		add_op(enc(6'h3d, D_FWD), OPA_Z, NPC, 1'b0, 64'hdead_beef, 1'b0, NPC, 1'b0, 1'b1);
		add_op(enc(6'h3a, D_BWD), OPA_N, NPC, 1'b1, T_BWD, 1'b1, T_BWD, 1'b0, 1'b1);
	endtask

	// Table row tagged with the next ROB slot
	function automatic op_t make_op(input int idx);
		op_t op;
		op = ops[idx];
		op.rob_idx = seq[`BR_ROB_IDX_W-1:0];
		return op;
	endfunction

	task automatic drive_req(input op_t op);
		req_valid_i       = 1'b1;
		req_npc_i         = op.npc;
		req_opa_i         = op.opa;
		req_inst_i        = op.inst;
		req_rob_idx_i     = op.rob_idx;
		req_pred_taken_i  = op.pred_taken;
		req_pred_target_i = op.pred_target;
	endtask

	// Random mode holds each level for a random stretch
	task automatic update_ready();
		case (ready_mode)
			MODE_LOW:  res_ready_i = 1'b0;
			MODE_HIGH: res_ready_i = 1'b1;
			default:
			begin
				if (stretch == 0)
				begin
					res_ready_i = ($urandom_range(0, 1) == 1);
					stretch     = $urandom_range(1, 30);
				end
				else
					stretch--;
			end
		endcase
	endtask

	// Result transfers on the coming edge, compare in issue order
	task automatic check_result();
		op_t want;
		if (res_valid_o && res_ready_i)
		begin
			if (exp_q.size() == 0)
				abort_run("Result received with no operation outstanding");
			else
			begin
				want = exp_q.pop_front();
				check_val("res_rob_idx_o", 64'(want.rob_idx), 64'(res_rob_idx_o));
				check_val("res_npc_o", want.npc, res_npc_o);
				check_val("res_taken_o", 64'(want.exp_taken), 64'(res_taken_o));
				check_val("res_target_o", want.exp_target, res_target_o);
				check_val("res_mispredict_o", 64'(want.exp_mis), 64'(res_mispredict_o));
				check_val("res_cond_o", 64'(want.exp_cond), 64'(res_cond_o));
			end
		end
	endtask

	// One cycle: falling edge, then output side
	task automatic step();
		@(negedge clk);
		update_ready();
		check_result();
	endtask

	task automatic send_op(input int idx);
		op_t op;
		int  waited;
		op = make_op(idx);
		drive_req(op);
		waited = 0;
		while (!req_ready_o)
		begin
			step();
			waited++;
			if (waited > TIMEOUT)
				abort_run("Timed out waiting for req_ready_o");
		end
		exp_q.push_back(op);
		seq++;
		step();
		req_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0)
		begin
			step();
			waited++;
			if (waited > TIMEOUT)
				abort_run("Timed out with results still outstanding");
		end
	endtask

	// Output stalled, push back to back until the request side closes
	task automatic fill_pipeline(output int n);
		n = 0;
		drive_req(make_op(0));
		while (req_ready_o)
		begin
			exp_q.push_back(make_op(n));
			seq++;
			n++;
			if (n > MAX_INFLIGHT)
				abort_run("req_ready_o still high with more than nine ops in flight");
			else
			begin
				step();
				drive_req(make_op(n)); // Held until accepted
			end
		end
		check_val("ops_in_flight", 64'(MAX_INFLIGHT), 64'(n));
		for (int i = 0; i < 20; i++)
		begin
			step();
			check_val("req_ready_o", 64'd0, 64'(req_ready_o));
			check_val("res_valid_o", 64'd1, 64'(res_valid_o));
		end
	endtask

	initial
	begin
		void'($urandom(32'hea4d_4eeb));
		rst               = 1'b1;
		req_valid_i       = 1'b0;
		req_npc_i         = '0;
		req_opa_i         = '0;
		req_inst_i        = '0;
		req_rob_idx_i     = '0;
		req_pred_taken_i  = 1'b0;
		req_pred_target_i = '0;
		res_ready_i       = 1'b0;
		build_table();

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		step();
		check_val("res_valid_o", 64'd0, 64'(res_valid_o));
		check_val("req_ready_o", 64'd1, 64'(req_ready_o));

		// Whole table, random gaps and random output stalls
		ready_mode = MODE_RAND;
		for (int i = 0; i < ops.size(); i++)
		begin
			gap = $urandom_range(0, 3);
			repeat (gap) step();
			send_op(i);
		end
		ready_mode = MODE_HIGH;
		wait_drain();
		repeat (2) step();

		// Fill all nine slots, then let it run out
		ready_mode = MODE_LOW;
		step();
		fill_pipeline(fill_cnt);
		ready_mode = MODE_RAND;
		for (int i = fill_cnt; i < ops.size(); i++)
		begin
			gap = $urandom_range(0, 2);
			repeat (gap) step();
			send_op(i);
		end
		ready_mode = MODE_HIGH;
		wait_drain();
		repeat (5) step(); // Extra results would trip check_result

		$display("sim passed");
		$finish;
	end

endmodule
